// File: Bender.yml
package:
  name: spi_core

dependencies: {}

sources:
  - files:
      - src/spi_reg_pkg.sv
      - src/spi_seq_pkg.sv
      - src/spi_reg_decode.sv
      - src/spi_shift_sequencer.sv
      - src/spi_bit_mem.sv
      - src/spi_core_top.sv
  - target: test
    files:
      - verif/spi_core_checker.sv
      - verif/tb_spi_core.sv

// File: project.f
src/spi_reg_pkg.sv
src/spi_seq_pkg.sv
src/spi_reg_decode.sv
src/spi_shift_sequencer.sv
src/spi_bit_mem.sv
src/spi_core_top.sv
verif/spi_core_checker.sv
verif/tb_spi_core.sv

// File: src/spi_bit_mem.sv
/*
 * SPI master bit memories
 * transmit and receive bytes, written and read byte-wise from the bus,
 * read and captured bit-wise by the shift sequencer
 */
`timescale 1ns/1ns
`default_nettype none

module spi_bit_mem (
    input  wire                                spi_clk,
    input  wire                                rst,
    input  wire                                mem_wr,
    input  wire  [spi_reg_pkg::MEM_BYTE_W-1:0] mem_byte,
    input  wire  [7:0]                         mem_wdata,
    input  wire  [spi_seq_pkg::BIT_ADDR_W-1:0] bit_addr,
    input  wire                                cap_en,
    input  wire                                sdo,
    output logic                               tx_bit,
    output logic [7:0]                         tx_rdata_byte,
    output logic [7:0]                         rx_rdata_byte
);

    logic [7:0] tx_mem [spi_reg_pkg::MEM_BYTES];
    logic [7:0] rx_mem [spi_reg_pkg::MEM_BYTES];

    logic [spi_seq_pkg::BIT_ADDR_W-1:0] cap_addr;

    // sdo seen at the end of frame cycle n belongs to bit n-1
    assign cap_addr = bit_addr - 1'b1;

    always_ff @(posedge spi_clk) begin
        if (mem_wr) begin
            tx_mem[mem_byte] <= mem_wdata;
        end
    end

    always_ff @(posedge spi_clk) begin
        if (cap_en && !rst) begin
            rx_mem[cap_addr[spi_seq_pkg::BIT_ADDR_W-1:3]][cap_addr[2:0]] <= sdo;
        end
    end

    // upper address bits pick the byte, lower three the bit in it
    assign tx_bit = tx_mem[bit_addr[spi_seq_pkg::BIT_ADDR_W-1:3]][bit_addr[2:0]];

    assign tx_rdata_byte = tx_mem[mem_byte];
    assign rx_rdata_byte = rx_mem[mem_byte];

endmodule

`default_nettype wire

// File: src/spi_core_top.sv
/*
 * SPI master core
 * byte-wide register bus in, SPI pins out, single clock domain
 */
`timescale 1ns/1ns
`default_nettype none

module spi_core_top (
    input  wire        spi_clk,
    input  wire        rst,
    input  wire [15:0] add,
    input  wire [7:0]  wdata,
    input  wire        wr,
    input  wire        rd,
    output wire [7:0]  rdata,
    input  wire        sdo,
    output wire        sclk,
    output wire        sdi,
    output wire        sen,
    output wire        sld
);

    wire                                start;
    wire                                soft_rst;
    wire [spi_seq_pkg::CNT_W-1:0]       bits;
    wire [spi_seq_pkg::CNT_W-1:0]       wait_len;
    wire [spi_seq_pkg::REP_W-1:0]       repeat_cnt;
    wire                                mem_wr;
    wire [spi_reg_pkg::MEM_BYTE_W-1:0]  mem_byte;
    wire [7:0]                          mem_wdata;
    wire [7:0]                          tx_rdata_byte;
    wire [7:0]                          rx_rdata_byte;
    wire [spi_seq_pkg::BIT_ADDR_W-1:0]  bit_addr;
    wire                                cap_en;
    wire                                tx_bit;
    wire                                frame_done;

    spi_reg_decode u_decode (
        .spi_clk       (spi_clk),
        .rst           (rst),
        .add           (add),
        .wdata         (wdata),
        .wr            (wr),
        .rd            (rd),
        .tx_rdata_byte (tx_rdata_byte),
        .rx_rdata_byte (rx_rdata_byte),
        .frame_done    (frame_done),
        .rdata         (rdata),
        .start         (start),
        .soft_rst      (soft_rst),
        .bits          (bits),
        .wait_len      (wait_len),
        .repeat_cnt    (repeat_cnt),
        .mem_wr        (mem_wr),
        .mem_byte      (mem_byte),
        .mem_wdata     (mem_wdata)
    );

    spi_shift_sequencer u_seq (
        .spi_clk    (spi_clk),
        .rst        (rst),
        .soft_rst   (soft_rst),
        .start      (start),
        .bits       (bits),
        .wait_len   (wait_len),
        .repeat_cnt (repeat_cnt),
        .tx_bit     (tx_bit),
        .sdo        (sdo),
        .bit_addr   (bit_addr),
        .cap_en     (cap_en),
        .frame_done (frame_done),
        .sclk       (sclk),
        .sdi        (sdi),
        .sen        (sen),
        .sld        (sld)
    );

    spi_bit_mem u_mem (
        .spi_clk       (spi_clk),
        .rst           (rst),
        .mem_wr        (mem_wr),
        .mem_byte      (mem_byte),
        .mem_wdata     (mem_wdata),
        .bit_addr      (bit_addr),
        .cap_en        (cap_en),
        .sdo           (sdo),
        .tx_bit        (tx_bit),
        .tx_rdata_byte (tx_rdata_byte),
        .rx_rdata_byte (rx_rdata_byte)
    );

endmodule

`default_nettype wire

// File: src/spi_reg_decode.sv
/*
 * SPI master register decode
 * configuration registers, start and soft-reset strobes, done flag,
 * byte routing into the transmit memory and the registered read mux
 */
`timescale 1ns/1ns
`default_nettype none

module spi_reg_decode (
    input  wire         spi_clk,
    input  wire         rst,
    input  wire  [15:0] add,
    input  wire  [7:0]  wdata,
    input  wire         wr,
    input  wire         rd,
    input  wire  [7:0]  tx_rdata_byte,
    input  wire  [7:0]  rx_rdata_byte,
    input  wire         frame_done,
    output logic [7:0]  rdata,
    output logic        start,
    output logic        soft_rst,
    output logic [spi_seq_pkg::CNT_W-1:0]      bits,
    output logic [spi_seq_pkg::CNT_W-1:0]      wait_len,
    output logic [spi_seq_pkg::REP_W-1:0]      repeat_cnt,
    output logic                               mem_wr,
    output logic [spi_reg_pkg::MEM_BYTE_W-1:0] mem_byte,
    output logic [7:0]                         mem_wdata
);

    logic        clr;
    logic        done;
    logic [7:0]  clk_div;
    logic        in_tx;
    logic        in_rx;
    logic [15:0] tx_off;

    // memories keep the MSB of each byte at the lowest bit address
    function automatic logic [7:0] bit_rev(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    assign soft_rst = wr && (add == spi_reg_pkg::ADDR_RESET);
    assign start    = wr && (add == spi_reg_pkg::ADDR_START);
    assign clr      = rst || soft_rst;

    assign in_tx  = (add >= spi_reg_pkg::ADDR_TX_BASE) && (add < spi_reg_pkg::ADDR_RX_BASE);
    assign in_rx  = (add >= spi_reg_pkg::ADDR_RX_BASE) && (add < spi_reg_pkg::ADDR_END);
    assign tx_off = add - spi_reg_pkg::ADDR_TX_BASE;

    // low offset bits pick the byte in either window
    assign mem_byte  = tx_off[spi_reg_pkg::MEM_BYTE_W-1:0];
    // receive window is read-only, so only transmit bytes get written
    assign mem_wr    = wr && in_tx;
    assign mem_wdata = bit_rev(wdata);

    always_ff @(posedge spi_clk) begin
        if (clr) begin
            clk_div    <= '0;
            bits       <= spi_reg_pkg::DEF_BITS;
            wait_len   <= '0;
            repeat_cnt <= spi_reg_pkg::DEF_REPEAT;
        end else if (wr) begin
            case (add)
                spi_reg_pkg::ADDR_CLK_DIV: clk_div         <= wdata;
                spi_reg_pkg::ADDR_BITS_LO: bits[7:0]       <= wdata;
                spi_reg_pkg::ADDR_BITS_HI: bits[15:8]      <= wdata;
                spi_reg_pkg::ADDR_WAIT_LO: wait_len[7:0]   <= wdata;
                spi_reg_pkg::ADDR_WAIT_HI: wait_len[15:8]  <= wdata;
                spi_reg_pkg::ADDR_REPEAT:  repeat_cnt      <= wdata;
                default: ;
            endcase
        end
    end

    // cleared by start, set again once the last frame has been loaded
    always_ff @(posedge spi_clk) begin
        if (clr) begin
            done <= 1'b1;
        end else if (start) begin
            done <= 1'b0;
        end else if (frame_done) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge spi_clk) begin
        if (rd) begin
            if (in_tx) begin
                rdata <= bit_rev(tx_rdata_byte);
            end else if (in_rx) begin
                rdata <= bit_rev(rx_rdata_byte);
            end else begin
                case (add)
                    spi_reg_pkg::ADDR_RESET:   rdata <= spi_reg_pkg::VERSION;
                    spi_reg_pkg::ADDR_START:   rdata <= {7'd0, done};
                    spi_reg_pkg::ADDR_CLK_DIV: rdata <= clk_div;
                    spi_reg_pkg::ADDR_BITS_LO: rdata <= bits[7:0];
                    spi_reg_pkg::ADDR_BITS_HI: rdata <= bits[15:8];
                    spi_reg_pkg::ADDR_WAIT_LO: rdata <= wait_len[7:0];
                    spi_reg_pkg::ADDR_WAIT_HI: rdata <= wait_len[15:8];
                    spi_reg_pkg::ADDR_REPEAT:  rdata <= repeat_cnt;
                    default:                   rdata <= '0;
                endcase
            end
        end
    end

    a_strobe_excl: assert property (@(posedge spi_clk) disable iff (rst)
        !(start && soft_rst));

    // sequencer may only report completion of a transfer still marked busy
    a_done_once: assert property (@(posedge spi_clk) disable iff (rst)
        frame_done |-> !done);

endmodule

`default_nettype wire

// File: src/spi_reg_pkg.sv
/*
 * SPI master register map
 * bus addresses, reset values of the configuration registers,
 * version code and sizing of the bit memories
 */
`default_nettype none

package spi_reg_pkg;

    // bytes held in each of the transmit and receive memories
    localparam int MEM_BYTES  = 2;
    localparam int MEM_BYTE_W = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;

    // configuration registers
    localparam logic [15:0] ADDR_RESET   = 16'd0;
    localparam logic [15:0] ADDR_START   = 16'd1;
    localparam logic [15:0] ADDR_CLK_DIV = 16'd2;
    localparam logic [15:0] ADDR_BITS_LO = 16'd3;
    localparam logic [15:0] ADDR_BITS_HI = 16'd4;
    localparam logic [15:0] ADDR_WAIT_LO = 16'd5;
    localparam logic [15:0] ADDR_WAIT_HI = 16'd6;
    localparam logic [15:0] ADDR_REPEAT  = 16'd7;

    // memory windows, transmit first and receive right after it
    localparam logic [15:0] ADDR_TX_BASE = 16'd8;
    localparam logic [15:0] ADDR_RX_BASE = ADDR_TX_BASE + 16'(MEM_BYTES);
    localparam logic [15:0] ADDR_END     = ADDR_RX_BASE + 16'(MEM_BYTES);

    // read back at address 0
    localparam logic [7:0] VERSION = 8'h01;

    // one full memory per frame, sent once
    localparam logic [15:0] DEF_BITS   = 16'(8 * MEM_BYTES);
    localparam logic [7:0]  DEF_REPEAT = 8'd1;

endpackage

`default_nettype wire

// File: src/spi_seq_pkg.sv
/*
 * SPI master sequencer constants
 * counter widths, bit address width and depth of the load-pulse detector
 */
`default_nettype none

package spi_seq_pkg;

    // frame counter covers bits plus the wait gap
    localparam int CNT_W = 16;

    // frames per transfer
    localparam int REP_W = 8;

    // addresses every bit of one memory
    localparam int BIT_ADDR_W = $clog2(8 * spi_reg_pkg::MEM_BYTES);

    // stages of the enable history used to find its falling edge
    localparam int LD_SYNC_W = 2;

endpackage

`default_nettype wire

// File: src/spi_shift_sequencer.sv
/*
 * SPI master shift sequencer
 * frame bit counter with wait gap and repeats, gated sclk,
 * falling-edge sdi and sen, and the sld load pulse after each frame
 */
`timescale 1ns/1ns
`default_nettype none

module spi_shift_sequencer (
    input  wire                               spi_clk,
    input  wire                               rst,
    input  wire                               soft_rst,
    input  wire                               start,
    input  wire  [spi_seq_pkg::CNT_W-1:0]     bits,
    input  wire  [spi_seq_pkg::CNT_W-1:0]     wait_len,
    input  wire  [spi_seq_pkg::REP_W-1:0]     repeat_cnt,
    input  wire                               tx_bit,
    input  wire                               sdo,
    output logic [spi_seq_pkg::BIT_ADDR_W-1:0] bit_addr,
    output logic                              cap_en,
    output logic                              frame_done,
    output logic                              sclk,
    output logic                              sdi,
    output logic                              sen,
    output logic                              sld
);

    logic                              clr;
    logic [spi_seq_pkg::CNT_W-1:0]     cnt;
    logic [spi_seq_pkg::CNT_W-1:0]     stop;
    logic                              at_stop;
    logic                              rep_start;
    logic                              rep_dly;
    logic                              en;
    logic [spi_seq_pkg::REP_W-1:0]     frame_idx;
    logic                              last_q;
    logic                              tx_q;
    logic [spi_seq_pkg::LD_SYNC_W-1:0] ld_sync;

    assign clr       = rst || soft_rst;
    assign stop      = bits + wait_len;
    assign at_stop   = (cnt != '0) && (cnt == stop);
    // repeat 0 keeps going until the next start or reset
    assign rep_start = at_stop && ((repeat_cnt == '0) || (frame_idx < repeat_cnt));

    always_ff @(posedge spi_clk) begin
        if (clr) begin
            rep_dly <= 1'b0;
        end else begin
            rep_dly <= rep_start;
        end
    end

    // 1..bits is the shift window, bits+1..stop the gap
    always_ff @(posedge spi_clk) begin
        if (clr) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= 1;
        end else if (at_stop) begin
            cnt <= '0;
        end else if (rep_dly) begin
            cnt <= 1;
        end else if (cnt != '0) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge spi_clk) begin
        if (clr) begin
            en <= 1'b0;
        end else if (start || rep_dly) begin
            en <= 1'b1;
        end else if (cnt == bits) begin
            en <= 1'b0;
        end
    end

    // index of the frame in flight, first frame is 1
    always_ff @(posedge spi_clk) begin
        if (clr || start) begin
            frame_idx <= 1;
        end else if (rep_dly) begin
            frame_idx <= frame_idx + 1'b1;
        end
    end

    // decided when the enable drops, used two cycles later with sld
    always_ff @(posedge spi_clk) begin
        if (clr || start) begin
            last_q <= 1'b0;
        end else if (en && (cnt == bits)) begin
            last_q <= (repeat_cnt != '0) && (frame_idx >= repeat_cnt);
        end
    end

    always_ff @(posedge spi_clk) begin
        if (clr) begin
            ld_sync <= '0;
            sld     <= 1'b0;
        end else begin
            ld_sync <= {ld_sync[spi_seq_pkg::LD_SYNC_W-2:0], en};
            sld     <= ld_sync[spi_seq_pkg::LD_SYNC_W-1] && !ld_sync[spi_seq_pkg::LD_SYNC_W-2];
        end
    end

    // one cycle of read latency so cycle n of the frame carries bit n-1
    always_ff @(posedge spi_clk) begin
        tx_q <= tx_bit;
    end

    always_ff @(negedge spi_clk) begin
        if (rst) begin
            sen <= 1'b0;
            sdi <= 1'b0;
        end else begin
            sen <= en;
            sdi <= tx_q && en;
        end
    end

    // sen only moves while the clock is low, so the gate cannot glitch
    assign sclk       = spi_clk && sen;
    assign bit_addr   = cnt[spi_seq_pkg::BIT_ADDR_W-1:0];
    assign cap_en     = en;
    assign frame_done = sld && last_q;

    // capture lands at cnt-1, which has to stay inside the receive memory
    a_addr_range: assert property (@(posedge spi_clk) disable iff (clr)
        en |-> (cnt <= spi_seq_pkg::CNT_W'(8 * spi_reg_pkg::MEM_BYTES)));

    a_sdo_known: assert property (@(posedge spi_clk) disable iff (rst)
        cap_en |-> !$isunknown(sdo));

endmodule

`default_nettype wire

// File: verif/spi_core_checker.sv
/*
 * SPI core checker
 * slave model answering on sdo, and monitor that compares sdi frames,
 * sclk pulse counts, sld pulses and done flag reads with the expected transfer
 */
`timescale 1ns/1ns
`default_nettype none

module spi_core_checker (
    input  wire        spi_clk,
    input  wire        rst,
    input  wire [15:0] add,
    input  wire        wr,
    input  wire        rd,
    input  wire [7:0]  rdata,
    input  wire        sclk,
    input  wire        sdi,
    input  wire        sen,
    input  wire        sld,
    output logic       sdo
);

    string       test_name = "none";
    int          mismatches = 0;
    int          failures = 0;
    int          sld_cnt = 0;
    int          sclk_total = 0;
    int          frames = 0;
    int          pulses = 0;
    int          exp_bits = 16;
    int          exp_frames = 0;
    int          sld_snap = 0;
    bit          check_frames = 1'b0;
    bit          flushed = 1'b1;
    bit          flush_snap = 1'b1;
    bit          done_rd_q = 1'b0;
    logic [15:0] exp_tx = '0;
    logic [15:0] reply = '0;
    logic [15:0] shreg = '0;
    logic [15:0] got = '0;

    initial begin
        sdo = 1'b0;
    end

    task automatic begin_test(input string name, input logic [15:0] tx,
                              input logic [15:0] rx, input int nbits,
                              input int nframes, input bit frames_on);
        test_name    = name;
        exp_tx       = tx;
        reply        = rx;
        exp_bits     = nbits;
        exp_frames   = nframes;
        check_frames = frames_on;
        frames       = 0;
    endtask

    task automatic compare(input string what, input logic [15:0] exp,
                           input logic [15:0] act);
        if (exp !== act) begin
            $display("MISMATCH test %s: %s expected %h actual %h",
                     test_name, what, exp, act);
            mismatches++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR test %s: %s", test_name, what);
        failures++;
    endtask

    // first nbits bits of a frame, MSB of byte 0 at bit 15
    function automatic logic [15:0] frame_mask(input int nbits);
        return 16'hffff << (16 - nbits);
    endfunction

    // first reply bit has to sit on sdo before the first sclk rise
    always @(posedge sen) begin
        shreg  = reply;
        sdo   <= shreg[15];
        got    = '0;
        pulses = 0;
    end

    always @(posedge sclk) begin
        if (pulses < 16) begin
            got[15 - pulses] = sdi;
        end
        pulses++;
        sclk_total++;
    end

    always @(negedge sclk) begin
        shreg = shreg << 1;
        sdo  <= shreg[15];
    end

    always @(negedge sen) begin
        if (check_frames) begin
            frames++;
            compare($sformatf("frame %0d sclk pulses", frames), exp_bits, pulses);
            compare($sformatf("frame %0d sdi bits", frames),
                    exp_tx & frame_mask(exp_bits), got & frame_mask(exp_bits));
        end
    end

    // done reads 1 once all expected sld pulses are in, or after a soft reset
    always @(posedge spi_clk) begin
        if (done_rd_q) begin
            compare("done flag", flush_snap || (sld_snap >= exp_frames), rdata[0]);
        end
        done_rd_q  = rd && (add == spi_reg_pkg::ADDR_START);
        flush_snap = flushed;
        sld_snap   = sld_cnt;
        if (rst || (wr && (add == spi_reg_pkg::ADDR_RESET))) begin
            flushed = 1'b1;
        end else if (wr && (add == spi_reg_pkg::ADDR_START)) begin
            flushed = 1'b0;
            sld_cnt = 0;
        end
        if (sld) begin
            sld_cnt++;
        end
    end

endmodule

`default_nettype wire

// File: verif/spi_core_vectors.txt
// tx bytes _ reply bytes _ bits _ wait _ repeat _ ctl, one 64-bit hex word per test
// ctl bit 7 fills tx and reply from xorshift, bits 6:0 give soft reset n cycles after start
A5C3_3C5A_10_00_01_00
9B00_6E00_08_03_01_00
1234_8765_0B_02_03_00
5A96_0F0F_10_00_02_00
0000_0000_0D_01_02_80
FFFF_AAAA_10_04_04_06

// File: verif/tb_spi_core.sv
/*
 * SPI core testbench
 * resets the core, checks register defaults, then runs each transfer of
 * the vector file over the bus and reads the receive memory back
 */
`timescale 1ns/1ns
`default_nettype none

module tb_spi_core;

    localparam int MAX_VECS = 8;
    localparam int POLL_MAX = 200;

    logic        spi_clk = 1'b0;
    logic        rst = 1'b1;
    logic [15:0] add = '0;
    logic [7:0]  wdata = '0;
    logic        wr = 1'b0;
    logic        rd = 1'b0;
    wire  [7:0]  rdata;
    wire         sdo;
    wire         sclk;
    wire         sdi;
    wire         sen;
    wire         sld;
    logic [63:0] vecs [MAX_VECS];
    logic [31:0] rng = 32'd2;

    always #4 spi_clk = ~spi_clk;

    spi_core_top u_dut (
        .spi_clk (spi_clk),
        .rst     (rst),
        .add     (add),
        .wdata   (wdata),
        .wr      (wr),
        .rd      (rd),
        .rdata   (rdata),
        .sdo     (sdo),
        .sclk    (sclk),
        .sdi     (sdi),
        .sen     (sen),
        .sld     (sld)
    );

    spi_core_checker u_chk (
        .spi_clk (spi_clk),
        .rst     (rst),
        .add     (add),
        .wr      (wr),
        .rd      (rd),
        .rdata   (rdata),
        .sclk    (sclk),
        .sdi     (sdi),
        .sen     (sen),
        .sld     (sld),
        .sdo     (sdo)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge spi_clk);
        add   <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge spi_clk);
        wr    <= 1'b0;
    endtask

    // rdata is registered, taken half a cycle after the strobe was sampled
    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge spi_clk);
        add <= a;
        rd  <= 1'b1;
        @(posedge spi_clk);
        rd  <= 1'b0;
        @(negedge spi_clk);
        d = rdata;
    endtask

    task automatic check_defaults();
        logic [7:0] d;
        bus_read(spi_reg_pkg::ADDR_RESET, d);
        u_chk.compare("version", spi_reg_pkg::VERSION, d);
        bus_read(spi_reg_pkg::ADDR_START, d);
        u_chk.compare("done readback", 1, d);
        bus_read(spi_reg_pkg::ADDR_BITS_LO, d);
        u_chk.compare("bits lo default", (8 * spi_reg_pkg::MEM_BYTES) & 255, d);
        bus_read(spi_reg_pkg::ADDR_BITS_HI, d);
        u_chk.compare("bits hi default", (8 * spi_reg_pkg::MEM_BYTES) >> 8, d);
        bus_read(spi_reg_pkg::ADDR_WAIT_LO, d);
        u_chk.compare("wait lo default", 0, d);
        bus_read(spi_reg_pkg::ADDR_WAIT_HI, d);
        u_chk.compare("wait hi default", 0, d);
        bus_read(spi_reg_pkg::ADDR_REPEAT, d);
        u_chk.compare("repeat default", 1, d);
    endtask

    task automatic poll_done(output bit ok);
        logic [7:0] d;
        int         n;
        ok = 1'b0;
        for (n = 0; (n < POLL_MAX) && !ok; n++) begin
            bus_read(spi_reg_pkg::ADDR_START, d);
            ok = d[0];
        end
    endtask

    task automatic run_vector(input int idx, input logic [63:0] v);
        logic [15:0] tx;
        logic [15:0] reply;
        logic [15:0] m;
        logic [7:0]  d;
        int          nbits;
        int          nrep;
        int          abort;
        int          clk_before;
        bit          ok;
        tx    = v[63:48];
        reply = v[47:32];
        nbits = v[31:24];
        nrep  = v[15:8];
        abort = v[6:0];
        if (v[7]) begin
            rng   = xorshift(rng);
            tx    = rng[15:0];
            rng   = xorshift(rng);
            reply = rng[15:0];
        end
        u_chk.begin_test($sformatf("vector_%0d", idx), tx, reply, nbits, nrep, abort == 0);
        bus_write(spi_reg_pkg::ADDR_TX_BASE, tx[15:8]);
        bus_write(spi_reg_pkg::ADDR_TX_BASE + 1, tx[7:0]);
        bus_write(spi_reg_pkg::ADDR_BITS_LO, v[31:24]);
        bus_write(spi_reg_pkg::ADDR_BITS_HI, 8'h00);
        bus_write(spi_reg_pkg::ADDR_WAIT_LO, v[23:16]);
        bus_write(spi_reg_pkg::ADDR_WAIT_HI, 8'h00);
        bus_write(spi_reg_pkg::ADDR_REPEAT, v[15:8]);
        bus_write(spi_reg_pkg::ADDR_START, 8'h00);
        if (abort != 0) begin
            // soft reset lands while the first frame is still shifting
            repeat (abort) @(posedge spi_clk);
            bus_write(spi_reg_pkg::ADDR_RESET, 8'h00);
            @(negedge spi_clk);
            clk_before = u_chk.sclk_total;
            repeat (20) @(posedge spi_clk);
            u_chk.compare("sen after soft reset", 0, sen);
            @(negedge spi_clk);
            u_chk.compare("sclk pulses after soft reset", clk_before, u_chk.sclk_total);
            check_defaults();
        end else begin
            poll_done(ok);
            if (!ok) begin
                u_chk.report_failure("done flag did not return to 1 within the poll limit");
            end
            u_chk.compare("sld pulses", nrep, u_chk.sld_cnt);
            u_chk.compare("frames seen", nrep, u_chk.frames);
            m = u_chk.frame_mask(nbits);
            bus_read(spi_reg_pkg::ADDR_RX_BASE, d);
            u_chk.compare("rx byte 0", reply[15:8] & m[15:8], d & m[15:8]);
            bus_read(spi_reg_pkg::ADDR_RX_BASE + 1, d);
            u_chk.compare("rx byte 1", reply[7:0] & m[7:0], d & m[7:0]);
        end
    endtask

    initial begin
        int i;
        for (i = 0; i < MAX_VECS; i++) begin
            vecs[i] = '0;
        end
        $readmemh("verif/spi_core_vectors.txt", vecs);
        repeat (5) @(posedge spi_clk);
        rst <= 1'b0;
        u_chk.begin_test("reset_defaults", '0, '0, 16, 0, 1'b0);
        check_defaults();
        // an all-zero word ends the list
        for (i = 0; (i < MAX_VECS) && (vecs[i] != '0); i++) begin
            run_vector(i, vecs[i]);
        end
        if (i == 0) begin
            u_chk.report_failure("no vectors were read from the vector file");
        end
        $display("errors: %0d mismatches, %0d other failures",
                 u_chk.mismatches, u_chk.failures);
        if ((u_chk.mismatches == 0) && (u_chk.failures == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
